//--- rtl/mesh_pkg.sv
package mesh_pkg;

    // Width of a packet's data word, and of every node accumulator.
    localparam int DATA_WIDTH = 16;

    // Width of the target-line field, so a page holds at most 16 lines.
    localparam int LINE_ID_WIDTH = 4;

    // Packet opcodes. A1 only acts on OP_READ and passes the rest through.
    typedef enum logic [1:0] {
        OP_PASS = 2'd0,
        OP_LOAD = 2'd1,
        OP_ADD  = 2'd2,
        OP_READ = 2'd3
    } mesh_op_t;

    // A pipe carries {op, line, data} with the opcode in the top bits.
    localparam int PACKET_WIDTH = $bits(mesh_op_t) + LINE_ID_WIDTH + DATA_WIDTH;

    // End-to-end latency of either channel through the page.
    // Both edge pipes, one registered node per line, and one node pipe
    // between each pair of adjacent lines.
    function automatic int channel_latency(
        input int line_count,
        input int edge_depth,
        input int node_depth
    );
        return (2 * edge_depth) + line_count + ((line_count - 1) * node_depth);
    endfunction

endpackage

//--- rtl/mesh_pipe.sv
// Fixed-depth delay line for one column of one channel.
// A packet entering on in_valid appears on out_valid exactly DEPTH cycles later.
module mesh_pipe #(
    parameter int DEPTH = 1,
    parameter int WIDTH = 1
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             in_valid,
    input  logic [WIDTH-1:0] in_bits,
    output logic             out_valid,
    output logic [WIDTH-1:0] out_bits
);

    // Stage 0 is next to the input, stage DEPTH-1 drives the output.
    logic [DEPTH-1:0] valid_q;
    logic [WIDTH-1:0] bits_q [DEPTH];

    // Valid strobes shift every cycle and are cleared on reset, so no stale
    // packet can leave the pipe after reset.
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Packet bits follow the strobes and are only meaningful alongside them.
    always_ff @(posedge clock) begin
        bits_q[0] <= in_bits;
        for (int i = 1; i < DEPTH; i++) begin
            bits_q[i] <= bits_q[i-1];
        end
    end

    assign out_valid = valid_q[DEPTH-1];
    assign out_bits  = bits_q[DEPTH-1];

endmodule

//--- rtl/mesh_line.sv
// One line of mesh nodes.
// Every column holds an accumulator that sits on both vertical channels.
// A0 travels upward and may load, add to or read the accumulator, while
// A1 travels downward and may only read it. Both channels leave the line
// through registers, so each node costs exactly one cycle.
module mesh_line #(
    parameter int NODE_COUNT = 2,
    parameter int LINE_INDEX = 0
) (
    input  logic                                               clock,
    input  logic                                               reset,

    // Channel A0, entering from the line below.
    input  logic               [NODE_COUNT-1:0]                a0_in_valid,
    input  mesh_pkg::mesh_op_t [NODE_COUNT-1:0]                a0_in_op,
    input  logic [NODE_COUNT-1:0][mesh_pkg::LINE_ID_WIDTH-1:0] a0_in_line,
    input  logic [NODE_COUNT-1:0][mesh_pkg::DATA_WIDTH-1:0]    a0_in_data,

    // Channel A0, leaving toward the line above.
    output logic               [NODE_COUNT-1:0]                a0_out_valid,
    output mesh_pkg::mesh_op_t [NODE_COUNT-1:0]                a0_out_op,
    output logic [NODE_COUNT-1:0][mesh_pkg::LINE_ID_WIDTH-1:0] a0_out_line,
    output logic [NODE_COUNT-1:0][mesh_pkg::DATA_WIDTH-1:0]    a0_out_data,

    // Channel A1, entering from the line above.
    input  logic               [NODE_COUNT-1:0]                a1_in_valid,
    input  mesh_pkg::mesh_op_t [NODE_COUNT-1:0]                a1_in_op,
    input  logic [NODE_COUNT-1:0][mesh_pkg::LINE_ID_WIDTH-1:0] a1_in_line,
    input  logic [NODE_COUNT-1:0][mesh_pkg::DATA_WIDTH-1:0]    a1_in_data,

    // Channel A1, leaving toward the line below.
    output logic               [NODE_COUNT-1:0]                a1_out_valid,
    output mesh_pkg::mesh_op_t [NODE_COUNT-1:0]                a1_out_op,
    output logic [NODE_COUNT-1:0][mesh_pkg::LINE_ID_WIDTH-1:0] a1_out_line,
    output logic [NODE_COUNT-1:0][mesh_pkg::DATA_WIDTH-1:0]    a1_out_data
);

    localparam int DW = mesh_pkg::DATA_WIDTH;
    localparam int LW = mesh_pkg::LINE_ID_WIDTH;

    // The line field value that addresses this line.
    localparam logic [LW-1:0] LINE_ID = LINE_INDEX[LW-1:0];

    // One accumulator per column.
    logic [NODE_COUNT-1:0][DW-1:0] acc;
    logic [NODE_COUNT-1:0][DW-1:0] acc_next;

    // A packet is only acted on when it is valid and aimed at this line.
    logic [NODE_COUNT-1:0]         a0_hit;
    logic [NODE_COUNT-1:0]         a1_hit;

    // Data words that each channel will forward from this node.
    logic [NODE_COUNT-1:0][DW-1:0] a0_data_next;
    logic [NODE_COUNT-1:0][DW-1:0] a1_data_next;

    always_comb begin
        for (int col = 0; col < NODE_COUNT; col++) begin
            a0_hit[col] = a0_in_valid[col] && (a0_in_line[col] == LINE_ID);
            a1_hit[col] = a1_in_valid[col] && (a1_in_line[col] == LINE_ID);

            acc_next[col]     = acc[col];
            a0_data_next[col] = a0_in_data[col];
            a1_data_next[col] = a1_in_data[col];

            if (a0_hit[col]) begin
                case (a0_in_op[col])
                    mesh_pkg::OP_LOAD: begin
                        acc_next[col] = a0_in_data[col];
                    end
                    mesh_pkg::OP_ADD: begin
                        // The sum wraps at 2^16 and also goes upward as data.
                        acc_next[col]     = acc[col] + a0_in_data[col];
                        a0_data_next[col] = acc[col] + a0_in_data[col];
                    end
                    mesh_pkg::OP_READ: begin
                        a0_data_next[col] = acc[col];
                    end
                    default: begin
                        // OP_PASS leaves the node untouched.
                    end
                endcase
            end

            // An A1 read takes the registered accumulator, so an A0 update
            // in the same cycle is not yet visible to it.
            if (a1_hit[col] && (a1_in_op[col] == mesh_pkg::OP_READ)) begin
                a1_data_next[col] = acc[col];
            end
        end
    end

    // Control state: accumulators and the output strobes.
    always_ff @(posedge clock) begin
        if (reset) begin
            acc          <= '0;
            a0_out_valid <= '0;
            a1_out_valid <= '0;
        end else begin
            acc          <= acc_next;
            a0_out_valid <= a0_in_valid;
            a1_out_valid <= a1_in_valid;
        end
    end

    // Packet payload registers. Opcode and line field pass straight on.
    always_ff @(posedge clock) begin
        a0_out_op   <= a0_in_op;
        a0_out_line <= a0_in_line;
        a0_out_data <= a0_data_next;
        a1_out_op   <= a1_in_op;
        a1_out_line <= a1_in_line;
        a1_out_data <= a1_data_next;
    end

endmodule

//--- rtl/mesh_page.sv
// A page of mesh lines joined by two pipelined vertical channels per column.
// A0 enters at the bottom edge and runs straight up through line 0 to the
// last line. A1 enters at the top edge and is whipstitched back down, from
// the last line to line 0. Each channel has an edge pipe at both page edges
// and a node pipe between every pair of adjacent lines.
module mesh_page #(
    parameter int LINE_COUNT      = 4,
    parameter int NODE_COUNT      = 2,
    parameter int EDGE_PIPE_DEPTH = 1,
    parameter int NODE_PIPE_DEPTH = 1
) (
    input  logic                                               clock,
    input  logic                                               reset,

    input  logic               [NODE_COUNT-1:0]                a0_in_valid,
    input  mesh_pkg::mesh_op_t [NODE_COUNT-1:0]                a0_in_op,
    input  logic [NODE_COUNT-1:0][mesh_pkg::LINE_ID_WIDTH-1:0] a0_in_line,
    input  logic [NODE_COUNT-1:0][mesh_pkg::DATA_WIDTH-1:0]    a0_in_data,

    output logic               [NODE_COUNT-1:0]                a0_out_valid,
    output mesh_pkg::mesh_op_t [NODE_COUNT-1:0]                a0_out_op,
    output logic [NODE_COUNT-1:0][mesh_pkg::LINE_ID_WIDTH-1:0] a0_out_line,
    output logic [NODE_COUNT-1:0][mesh_pkg::DATA_WIDTH-1:0]    a0_out_data,

    input  logic               [NODE_COUNT-1:0]                a1_in_valid,
    input  mesh_pkg::mesh_op_t [NODE_COUNT-1:0]                a1_in_op,
    input  logic [NODE_COUNT-1:0][mesh_pkg::LINE_ID_WIDTH-1:0] a1_in_line,
    input  logic [NODE_COUNT-1:0][mesh_pkg::DATA_WIDTH-1:0]    a1_in_data,

    output logic               [NODE_COUNT-1:0]                a1_out_valid,
    output mesh_pkg::mesh_op_t [NODE_COUNT-1:0]                a1_out_op,
    output logic [NODE_COUNT-1:0][mesh_pkg::LINE_ID_WIDTH-1:0] a1_out_line,
    output logic [NODE_COUNT-1:0][mesh_pkg::DATA_WIDTH-1:0]    a1_out_data
);

    localparam int DW  = mesh_pkg::DATA_WIDTH;
    localparam int LW  = mesh_pkg::LINE_ID_WIDTH;
    localparam int OPW = $bits(mesh_pkg::mesh_op_t);
    localparam int PW  = mesh_pkg::PACKET_WIDTH;

    // Ports of every line instance, indexed first by line.
    logic               [NODE_COUNT-1:0]         line_a0_in_valid  [LINE_COUNT];
    mesh_pkg::mesh_op_t [NODE_COUNT-1:0]         line_a0_in_op     [LINE_COUNT];
    logic               [NODE_COUNT-1:0][LW-1:0] line_a0_in_line   [LINE_COUNT];
    logic               [NODE_COUNT-1:0][DW-1:0] line_a0_in_data   [LINE_COUNT];
    logic               [NODE_COUNT-1:0]         line_a0_out_valid [LINE_COUNT];
    mesh_pkg::mesh_op_t [NODE_COUNT-1:0]         line_a0_out_op    [LINE_COUNT];
    logic               [NODE_COUNT-1:0][LW-1:0] line_a0_out_line  [LINE_COUNT];
    logic               [NODE_COUNT-1:0][DW-1:0] line_a0_out_data  [LINE_COUNT];
    logic               [NODE_COUNT-1:0]         line_a1_in_valid  [LINE_COUNT];
    mesh_pkg::mesh_op_t [NODE_COUNT-1:0]         line_a1_in_op     [LINE_COUNT];
    logic               [NODE_COUNT-1:0][LW-1:0] line_a1_in_line   [LINE_COUNT];
    logic               [NODE_COUNT-1:0][DW-1:0] line_a1_in_data   [LINE_COUNT];
    logic               [NODE_COUNT-1:0]         line_a1_out_valid [LINE_COUNT];
    mesh_pkg::mesh_op_t [NODE_COUNT-1:0]         line_a1_out_op    [LINE_COUNT];
    logic               [NODE_COUNT-1:0][LW-1:0] line_a1_out_line  [LINE_COUNT];
    logic               [NODE_COUNT-1:0][DW-1:0] line_a1_out_data  [LINE_COUNT];

    for (genvar l = 0; l < LINE_COUNT; l++) begin : g_line
        mesh_line #(
            .NODE_COUNT   (NODE_COUNT),
            .LINE_INDEX   (l)
        ) u_line (
            .clock        (clock),
            .reset        (reset),
            .a0_in_valid  (line_a0_in_valid[l]),
            .a0_in_op     (line_a0_in_op[l]),
            .a0_in_line   (line_a0_in_line[l]),
            .a0_in_data   (line_a0_in_data[l]),
            .a0_out_valid (line_a0_out_valid[l]),
            .a0_out_op    (line_a0_out_op[l]),
            .a0_out_line  (line_a0_out_line[l]),
            .a0_out_data  (line_a0_out_data[l]),
            .a1_in_valid  (line_a1_in_valid[l]),
            .a1_in_op     (line_a1_in_op[l]),
            .a1_in_line   (line_a1_in_line[l]),
            .a1_in_data   (line_a1_in_data[l]),
            .a1_out_valid (line_a1_out_valid[l]),
            .a1_out_op    (line_a1_out_op[l]),
            .a1_out_line  (line_a1_out_line[l]),
            .a1_out_data  (line_a1_out_data[l])
        );
    end

    for (genvar col = 0; col < NODE_COUNT; col++) begin : g_column
        // Pipe p of A0 feeds line p, and pipe LINE_COUNT feeds the top edge.
        // Pipe p of A1 feeds line p-1, and pipe 0 feeds the bottom edge.
        logic [LINE_COUNT:0]         a0_pipe_in_valid;
        logic [LINE_COUNT:0]         a0_pipe_out_valid;
        logic [LINE_COUNT:0][PW-1:0] a0_pipe_in_bits;
        logic [LINE_COUNT:0][PW-1:0] a0_pipe_out_bits;
        logic [LINE_COUNT:0]         a1_pipe_in_valid;
        logic [LINE_COUNT:0]         a1_pipe_out_valid;
        logic [LINE_COUNT:0][PW-1:0] a1_pipe_in_bits;
        logic [LINE_COUNT:0][PW-1:0] a1_pipe_out_bits;

        for (genvar p = 0; p <= LINE_COUNT; p++) begin : g_pipe
            // The outermost pipes sit on the page edges.
            localparam int DEPTH = ((p == 0) || (p == LINE_COUNT)) ?
                                   EDGE_PIPE_DEPTH : NODE_PIPE_DEPTH;

            mesh_pipe #(.DEPTH(DEPTH), .WIDTH(PW)) u_a0_pipe (
                .clock     (clock),
                .reset     (reset),
                .in_valid  (a0_pipe_in_valid[p]),
                .in_bits   (a0_pipe_in_bits[p]),
                .out_valid (a0_pipe_out_valid[p]),
                .out_bits  (a0_pipe_out_bits[p])
            );

            mesh_pipe #(.DEPTH(DEPTH), .WIDTH(PW)) u_a1_pipe (
                .clock     (clock),
                .reset     (reset),
                .in_valid  (a1_pipe_in_valid[p]),
                .in_bits   (a1_pipe_in_bits[p]),
                .out_valid (a1_pipe_out_valid[p]),
                .out_bits  (a1_pipe_out_bits[p])
            );
        end

        // Page edges. A0 enters at the bottom, A1 at the top.
        assign a0_pipe_in_valid[0]          = a0_in_valid[col];
        assign a0_pipe_in_bits[0]           = {a0_in_op[col], a0_in_line[col], a0_in_data[col]};
        assign a1_pipe_in_valid[LINE_COUNT] = a1_in_valid[col];
        assign a1_pipe_in_bits[LINE_COUNT]  = {a1_in_op[col], a1_in_line[col], a1_in_data[col]};

        assign a0_out_valid[col] = a0_pipe_out_valid[LINE_COUNT];
        assign a0_out_op[col]    = mesh_pkg::mesh_op_t'(a0_pipe_out_bits[LINE_COUNT][PW-1 -: OPW]);
        assign a0_out_line[col]  = a0_pipe_out_bits[LINE_COUNT][DW +: LW];
        assign a0_out_data[col]  = a0_pipe_out_bits[LINE_COUNT][DW-1:0];
        assign a1_out_valid[col] = a1_pipe_out_valid[0];
        assign a1_out_op[col]    = mesh_pkg::mesh_op_t'(a1_pipe_out_bits[0][PW-1 -: OPW]);
        assign a1_out_line[col]  = a1_pipe_out_bits[0][DW +: LW];
        assign a1_out_data[col]  = a1_pipe_out_bits[0][DW-1:0];

        for (genvar l = 0; l < LINE_COUNT; l++) begin : g_stitch
            // A0 goes straight through: pipe l into line l, line l into pipe l+1.
            assign line_a0_in_valid[l][col] = a0_pipe_out_valid[l];
            assign line_a0_in_op[l][col]    =
                mesh_pkg::mesh_op_t'(a0_pipe_out_bits[l][PW-1 -: OPW]);
            assign line_a0_in_line[l][col]  = a0_pipe_out_bits[l][DW +: LW];
            assign line_a0_in_data[l][col]  = a0_pipe_out_bits[l][DW-1:0];
            assign a0_pipe_in_valid[l+1]    = line_a0_out_valid[l][col];
            assign a0_pipe_in_bits[l+1]     = {line_a0_out_op[l][col],
                                               line_a0_out_line[l][col],
                                               line_a0_out_data[l][col]};

            // A1 is whipstitched: pipe l+1 into line l, line l into pipe l.
            assign line_a1_in_valid[l][col] = a1_pipe_out_valid[l+1];
            assign line_a1_in_op[l][col]    =
                mesh_pkg::mesh_op_t'(a1_pipe_out_bits[l+1][PW-1 -: OPW]);
            assign line_a1_in_line[l][col]  = a1_pipe_out_bits[l+1][DW +: LW];
            assign line_a1_in_data[l][col]  = a1_pipe_out_bits[l+1][DW-1:0];
            assign a1_pipe_in_valid[l]      = line_a1_out_valid[l][col];
            assign a1_pipe_in_bits[l]       = {line_a1_out_op[l][col],
                                               line_a1_out_line[l][col],
                                               line_a1_out_data[l][col]};
        end
    end

endmodule

//--- test/mesh_page_checker.sv
// Protocol assertions bound into every mesh_page instance.
// Both channels have a fixed latency and no back-pressure, so each valid
// input must reappear at the matching output after exactly LATENCY cycles.
module mesh_page_checker #(
    parameter int LINE_COUNT      = 4,
    parameter int NODE_COUNT      = 2,
    parameter int EDGE_PIPE_DEPTH = 1,
    parameter int NODE_PIPE_DEPTH = 1
) (
    input logic                  clock,
    input logic                  reset,
    input logic [NODE_COUNT-1:0] a0_in_valid,
    input logic [NODE_COUNT-1:0] a0_out_valid,
    input logic [NODE_COUNT-1:0] a1_in_valid,
    input logic [NODE_COUNT-1:0] a1_out_valid
);

    // Two edge pipes, one register per line and a node pipe between lines.
    localparam int LATENCY = mesh_pkg::channel_latency(LINE_COUNT, EDGE_PIPE_DEPTH,
                                                       NODE_PIPE_DEPTH);

    int assertion_failures = 0;

    quiet_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> ((a0_out_valid == '0) && (a1_out_valid == '0)))
        else begin
            assertion_failures++;
            $error("An output valid was high in the first cycle after reset.");
        end

    for (genvar c = 0; c < NODE_COUNT; c++) begin : g_column
        a0_fixed_latency: assert property (@(posedge clock) disable iff (reset)
            $past(a0_in_valid[c], LATENCY) |-> a0_out_valid[c])
            else begin
                assertion_failures++;
                $error("A0 packet on column %0d did not arrive on time.", c);
            end

        a1_fixed_latency: assert property (@(posedge clock) disable iff (reset)
            $past(a1_in_valid[c], LATENCY) |-> a1_out_valid[c])
            else begin
                assertion_failures++;
                $error("A1 packet on column %0d did not arrive on time.", c);
            end
    end

endmodule

bind mesh_page mesh_page_checker #(
    .LINE_COUNT      (LINE_COUNT),
    .NODE_COUNT      (NODE_COUNT),
    .EDGE_PIPE_DEPTH (EDGE_PIPE_DEPTH),
    .NODE_PIPE_DEPTH (NODE_PIPE_DEPTH)
) u_checker (
    .clock        (clock),
    .reset        (reset),
    .a0_in_valid  (a0_in_valid),
    .a0_out_valid (a0_out_valid),
    .a1_in_valid  (a1_in_valid),
    .a1_out_valid (a1_out_valid)
);

//--- test/mesh_page_monitor.sv
// Scoreboard for the mesh page.
// Every packet driven into a channel is queued with the cycle in which it
// is due at the far edge. Outputs are compared against the queue heads.
module mesh_page_monitor #(
    parameter int NODE_COUNT = 2,
    parameter int LATENCY    = 9
) (
    input  logic                                               clock,
    input  logic                                               reset,
    input  logic               [NODE_COUNT-1:0]                a0_in_valid,
    input  mesh_pkg::mesh_op_t [NODE_COUNT-1:0]                a0_in_op,
    input  logic [NODE_COUNT-1:0][mesh_pkg::LINE_ID_WIDTH-1:0] a0_in_line,
    input  logic [NODE_COUNT-1:0][mesh_pkg::DATA_WIDTH-1:0]    a0_exp_data,
    input  logic               [NODE_COUNT-1:0]                a0_out_valid,
    input  mesh_pkg::mesh_op_t [NODE_COUNT-1:0]                a0_out_op,
    input  logic [NODE_COUNT-1:0][mesh_pkg::LINE_ID_WIDTH-1:0] a0_out_line,
    input  logic [NODE_COUNT-1:0][mesh_pkg::DATA_WIDTH-1:0]    a0_out_data,
    input  logic               [NODE_COUNT-1:0]                a1_in_valid,
    input  mesh_pkg::mesh_op_t [NODE_COUNT-1:0]                a1_in_op,
    input  logic [NODE_COUNT-1:0][mesh_pkg::LINE_ID_WIDTH-1:0] a1_in_line,
    input  logic [NODE_COUNT-1:0][mesh_pkg::DATA_WIDTH-1:0]    a1_exp_data,
    input  logic               [NODE_COUNT-1:0]                a1_out_valid,
    input  mesh_pkg::mesh_op_t [NODE_COUNT-1:0]                a1_out_op,
    input  logic [NODE_COUNT-1:0][mesh_pkg::LINE_ID_WIDTH-1:0] a1_out_line,
    input  logic [NODE_COUNT-1:0][mesh_pkg::DATA_WIDTH-1:0]    a1_out_data,
    output int                                                 value_errors,
    output int                                                 flow_errors,
    output logic                                               idle
);

    typedef struct packed {
        int                                due;
        mesh_pkg::mesh_op_t                op;
        logic [mesh_pkg::LINE_ID_WIDTH-1:0] line;
        logic [mesh_pkg::DATA_WIDTH-1:0]    data;
    } expect_t;

    // Index 0 is channel A0, index 1 is channel A1.
    expect_t pending [2][NODE_COUNT][$];
    int      cycle;
    int      outstanding = 0;

    assign idle = (outstanding == 0);

    task automatic check_output(
        input int                                 ch,
        input int                                 col,
        input logic                               valid,
        input mesh_pkg::mesh_op_t                 op,
        input logic [mesh_pkg::LINE_ID_WIDTH-1:0] line,
        input logic [mesh_pkg::DATA_WIDTH-1:0]    data
    );
        expect_t head;
        logic    due_now;
        due_now = (pending[ch][col].size() > 0) && (pending[ch][col][0].due == cycle);
        if (due_now) begin
            head = pending[ch][col].pop_front();
            outstanding--;
            if (!valid) begin
                flow_errors++;
                $display("At time %0t channel A%0d column %0d gave no packet where one was due",
                         $time, ch, col);
            end else if ((op != head.op) || (line != head.line) || (data != head.data)) begin
                value_errors++;
                $display("error at time %0t: A%0d column %0d got op %0d line %0d data %h, %s",
                         $time, ch, col, op, line, data, "fields differ from expected");
                $display("    expected op %0d line %0d data %h", head.op, head.line, head.data);
            end
        end else if (valid) begin
            flow_errors++;
            $display("At time %0t channel A%0d column %0d put out a packet nobody expected",
                     $time, ch, col);
        end
    endtask

    task automatic record_expected(
        input int                                 ch,
        input int                                 col,
        input mesh_pkg::mesh_op_t                 op,
        input logic [mesh_pkg::LINE_ID_WIDTH-1:0] line,
        input logic [mesh_pkg::DATA_WIDTH-1:0]    data
    );
        expect_t entry;
        entry.due  = cycle + LATENCY;
        entry.op   = op;
        entry.line = line;
        entry.data = data;
        pending[ch][col].push_back(entry);
        outstanding++;
    endtask

    // Outputs are checked before new packets are queued, since a packet
    // queued now is never due in the same cycle.
    always @(posedge clock) begin
        if (reset) begin
            cycle        = 0;
            value_errors = 0;
            flow_errors  = 0;
        end else begin
            for (int col = 0; col < NODE_COUNT; col++) begin
                check_output(0, col, a0_out_valid[col], a0_out_op[col], a0_out_line[col],
                             a0_out_data[col]);
                check_output(1, col, a1_out_valid[col], a1_out_op[col], a1_out_line[col],
                             a1_out_data[col]);
                if (a0_in_valid[col]) begin
                    record_expected(0, col, a0_in_op[col], a0_in_line[col], a0_exp_data[col]);
                end
                if (a1_in_valid[col]) begin
                    record_expected(1, col, a1_in_op[col], a1_in_line[col], a1_exp_data[col]);
                end
            end
            cycle = cycle + 1;
        end
    end

endmodule

//--- test/tb_mesh_page.sv
module tb_mesh_page;

    localparam int LINE_COUNT      = 4;
    localparam int NODE_COUNT      = 2;
    localparam int EDGE_PIPE_DEPTH = 1;
    localparam int NODE_PIPE_DEPTH = 1;
    localparam int DW              = mesh_pkg::DATA_WIDTH;
    localparam int LW              = mesh_pkg::LINE_ID_WIDTH;

    // A packet crosses two edge pipes, every line and the node pipes between lines.
    localparam int LATENCY = mesh_pkg::channel_latency(LINE_COUNT, EDGE_PIPE_DEPTH,
                                                       NODE_PIPE_DEPTH);

    localparam int ROW_COUNT     = 20;
    localparam int RANDOM_CYCLES = 24;
    localparam int CLOCK_PERIOD  = 40;
    localparam int WATCHDOG_TIME = (ROW_COUNT + RANDOM_CYCLES + LATENCY + 10) * CLOCK_PERIOD * 2;

    typedef struct packed {
        logic               channel;
        logic [3:0]         column;
        mesh_pkg::mesh_op_t op;
        logic [LW-1:0]      line;
        logic [DW-1:0]      data;
        logic [DW-1:0]      expected;
    } stim_row_t;

    logic                                clock;
    logic                                reset;
    logic               [NODE_COUNT-1:0] a0_in_valid;
    mesh_pkg::mesh_op_t [NODE_COUNT-1:0] a0_in_op;
    logic [NODE_COUNT-1:0][LW-1:0]       a0_in_line;
    logic [NODE_COUNT-1:0][DW-1:0]       a0_in_data;
    logic [NODE_COUNT-1:0][DW-1:0]       a0_exp_data;
    logic               [NODE_COUNT-1:0] a0_out_valid;
    mesh_pkg::mesh_op_t [NODE_COUNT-1:0] a0_out_op;
    logic [NODE_COUNT-1:0][LW-1:0]       a0_out_line;
    logic [NODE_COUNT-1:0][DW-1:0]       a0_out_data;
    logic               [NODE_COUNT-1:0] a1_in_valid;
    mesh_pkg::mesh_op_t [NODE_COUNT-1:0] a1_in_op;
    logic [NODE_COUNT-1:0][LW-1:0]       a1_in_line;
    logic [NODE_COUNT-1:0][DW-1:0]       a1_in_data;
    logic [NODE_COUNT-1:0][DW-1:0]       a1_exp_data;
    logic               [NODE_COUNT-1:0] a1_out_valid;
    mesh_pkg::mesh_op_t [NODE_COUNT-1:0] a1_out_op;
    logic [NODE_COUNT-1:0][LW-1:0]       a1_out_line;
    logic [NODE_COUNT-1:0][DW-1:0]       a1_out_data;

    int          value_errors;
    int          flow_errors;
    logic        idle;
    stim_row_t   stim_table [ROW_COUNT];
    int          row_fill = 0;
    logic [31:0] lfsr_state;

    mesh_page #(
        .LINE_COUNT      (LINE_COUNT),
        .NODE_COUNT      (NODE_COUNT),
        .EDGE_PIPE_DEPTH (EDGE_PIPE_DEPTH),
        .NODE_PIPE_DEPTH (NODE_PIPE_DEPTH)
    ) UUT (.*);

    mesh_page_monitor #(.NODE_COUNT(NODE_COUNT), .LATENCY(LATENCY)) u_monitor (.*);

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {1'b0, state[31:1]} ^ (state[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // Takes count bits from the LFSR, one step per bit.
    task automatic random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic clear_inputs();
        for (int col = 0; col < NODE_COUNT; col++) begin
            a0_in_valid[col] = 1'b0;
            a0_in_op[col]    = mesh_pkg::OP_PASS;
            a0_in_line[col]  = '0;
            a0_in_data[col]  = '0;
            a0_exp_data[col] = '0;
            a1_in_valid[col] = 1'b0;
            a1_in_op[col]    = mesh_pkg::OP_PASS;
            a1_in_line[col]  = '0;
            a1_in_data[col]  = '0;
            a1_exp_data[col] = '0;
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic add_row(input logic channel, input logic [3:0] column,
                           input mesh_pkg::mesh_op_t op, input logic [LW-1:0] line,
                           input logic [DW-1:0] data, input logic [DW-1:0] expected);
        stim_table[row_fill] = '{channel, column, op, line, data, expected};
        row_fill++;
    endtask

    // Channel 0 is A0 and channel 1 is A1. Line 9 addresses no node.
    // A1 reads are placed late enough that the A0 updates before them have landed.
    task automatic fill_table();
        add_row(1'b0, 4'd0, mesh_pkg::OP_PASS, 4'd0, 16'h1234, 16'h1234);
        add_row(1'b0, 4'd1, mesh_pkg::OP_LOAD, 4'd9, 16'hbeef, 16'hbeef);
        add_row(1'b1, 4'd0, mesh_pkg::OP_READ, 4'd9, 16'h5a5a, 16'h5a5a);
        add_row(1'b1, 4'd1, mesh_pkg::OP_PASS, 4'd3, 16'h0f0f, 16'h0f0f);
        add_row(1'b0, 4'd1, mesh_pkg::OP_LOAD, 4'd2, 16'habcd, 16'habcd);
        add_row(1'b0, 4'd1, mesh_pkg::OP_READ, 4'd2, 16'h0000, 16'habcd);
        add_row(1'b0, 4'd0, mesh_pkg::OP_ADD,  4'd1, 16'h0003, 16'h0003);
        add_row(1'b0, 4'd0, mesh_pkg::OP_ADD,  4'd1, 16'hfffe, 16'h0001);
        add_row(1'b0, 4'd0, mesh_pkg::OP_ADD,  4'd1, 16'h0010, 16'h0011);
        add_row(1'b0, 4'd0, mesh_pkg::OP_READ, 4'd0, 16'h7777, 16'h0000);
        add_row(1'b0, 4'd1, mesh_pkg::OP_READ, 4'd1, 16'h7777, 16'h0000);
        add_row(1'b0, 4'd0, mesh_pkg::OP_READ, 4'd2, 16'h7777, 16'h0000);
        add_row(1'b1, 4'd1, mesh_pkg::OP_READ, 4'd2, 16'h0000, 16'habcd);
        add_row(1'b1, 4'd0, mesh_pkg::OP_READ, 4'd1, 16'h0000, 16'h0011);
        add_row(1'b1, 4'd0, mesh_pkg::OP_LOAD, 4'd1, 16'h1111, 16'h1111);
        add_row(1'b1, 4'd0, mesh_pkg::OP_ADD,  4'd1, 16'h2222, 16'h2222);
        add_row(1'b1, 4'd1, mesh_pkg::OP_ADD,  4'd2, 16'h0001, 16'h0001);
        add_row(1'b0, 4'd1, mesh_pkg::OP_READ, 4'd3, 16'h0000, 16'h0000);
        add_row(1'b1, 4'd1, mesh_pkg::OP_READ, 4'd2, 16'h0000, 16'habcd);
        add_row(1'b0, 4'd0, mesh_pkg::OP_READ, 4'd1, 16'h0000, 16'h0011);
    endtask

    task automatic apply_row(input stim_row_t row);
        clear_inputs();
        if (row.channel == 1'b0) begin
            a0_in_valid[row.column] = 1'b1;
            a0_in_op[row.column]    = row.op;
            a0_in_line[row.column]  = row.line;
            a0_in_data[row.column]  = row.data;
            a0_exp_data[row.column] = row.expected;
        end else begin
            a1_in_valid[row.column] = 1'b1;
            a1_in_op[row.column]    = row.op;
            a1_in_line[row.column]  = row.line;
            a1_in_data[row.column]  = row.data;
            a1_exp_data[row.column] = row.expected;
        end
        next_cycle();
    endtask

    // Pass packets on every column of both channels leave unchanged.
    task automatic apply_random_cycle();
        logic [31:0] bits;
        for (int col = 0; col < NODE_COUNT; col++) begin
            a0_in_valid[col] = 1'b1;
            a0_in_op[col]    = mesh_pkg::OP_PASS;
            random_bits(LW, bits);
            a0_in_line[col]  = bits[LW-1:0];
            random_bits(DW, bits);
            a0_in_data[col]  = bits[DW-1:0];
            a0_exp_data[col] = bits[DW-1:0];
            a1_in_valid[col] = 1'b1;
            a1_in_op[col]    = mesh_pkg::OP_PASS;
            random_bits(LW, bits);
            a1_in_line[col]  = bits[LW-1:0];
            random_bits(DW, bits);
            a1_in_data[col]  = bits[DW-1:0];
            a1_exp_data[col] = bits[DW-1:0];
        end
        next_cycle();
    endtask

    initial begin
        int total;
        lfsr_state = 32'h3eb8_0031;
        clock      = 1'b0;
        reset      = 1'b1;
        clear_inputs();
        fill_table();
        repeat (3) @(posedge clock);
        #2;
        reset = 1'b0;
        // Quiet cycles. The monitor flags any output valid seen here.
        repeat (4) next_cycle();
        for (int r = 0; r < ROW_COUNT; r++) begin
            apply_row(stim_table[r]);
        end
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            apply_random_cycle();
        end
        clear_inputs();
        next_cycle();
        wait (idle);
        repeat (2) next_cycle();
        total = value_errors + flow_errors + UUT.u_checker.assertion_failures;
        $display("Checks done: %0d wrong values, %0d missing or unexpected packets, %0d %s",
                 value_errors, flow_errors, UUT.u_checker.assertion_failures,
                 "assertion failures");
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- filelist.f
rtl/mesh_pkg.sv
rtl/mesh_pipe.sv
rtl/mesh_line.sv
rtl/mesh_page.sv
test/mesh_page_checker.sv
test/mesh_page_monitor.sv
test/tb_mesh_page.sv

//--- run_sim.sh
#!/bin/sh
# Builds the mesh page testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_mesh_page
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_mesh_page \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG_FILE"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi
